//--- hdl/f2_glue_pkg.sv
package f2_glue_pkg;

    ////////////////////////////////////////////////////////////
    // Bus types

    typedef logic [15:0] word_t;     // CPU data word
    typedef logic [22:0] cpu_addr_t; // Byte address bits 23..1

    // 68000 function codes
    typedef enum logic [2:0] {
        FC_USER_DATA  = 3'd1,
        FC_USER_PROG  = 3'd2,
        FC_SUPER_DATA = 3'd5,
        FC_SUPER_PROG = 3'd6,
        FC_IACK       = 3'd7
    } fc_t;

    // Decoded device region
    typedef enum logic [2:0] {
        REG_NONE,
        REG_ROM,
        REG_WORK,
        REG_COLOR,
        REG_IO,
        REG_SOUND,
        REG_SCREEN,
        REG_OBJECT
    } region_t;

    typedef logic [2:0] ipl_t; // Active low, as seen on IPL2..0

    ////////////////////////////////////////////////////////////
    // Memory map, upper address byte

    localparam logic [7:0] ROM_FIRST    = 8'h00;
    localparam logic [7:0] ROM_LAST     = 8'h0F; // 1 MB program ROM

    localparam logic [7:0] WORK         = 8'h10;
    localparam logic [7:0] COLOR        = 8'h20;
    localparam logic [7:0] IO           = 8'h30;
    localparam logic [7:0] SOUND        = 8'h32;

    localparam logic [7:0] SCREEN_FIRST = 8'h80;
    localparam logic [7:0] SCREEN_LAST  = 8'h81;

    localparam logic [7:0] OBJECT       = 8'h90;

    ////////////////////////////////////////////////////////////
    // Interrupt levels

    localparam logic [2:0] IRQ_VBL_LEVEL = 3'd5; // Vblank start
    localparam logic [2:0] IRQ_DMA_LEVEL = 3'd6; // Sprite DMA done

endpackage

//--- hdl/cpu_bus_if.sv
`timescale 1ns/1ns

interface cpu_bus_if import f2_glue_pkg::*; ();

    logic      as_n;  // Address strobe
    logic [1:0] ds_n; // Upper, lower data strobe
    logic      rw;    // 1 = read
    fc_t       fc;
    cpu_addr_t addr;
    word_t     dout;  // CPU write data

    // Region decode
    modport decode (
        input as_n,
        input fc,
        input addr
    );

    // Interrupt acknowledge detection
    modport irq (
        input as_n,
        input fc,
        input ds_n,
        input addr
    );

    modport mux (
        input as_n
    );

endinterface

//--- hdl/cpu_cen.sv
`timescale 1ns/1ns

module cpu_cen #(
    parameter logic [9:0] CEN_N = 10'd172,
    parameter logic [9:0] CEN_M = 10'd765
) (
    input  logic clk,
    input  logic reset,

    input  logic rom_ready,
    input  logic run,

    output logic ce_12m,
    output logic ce_cpu,
    output logic ce_cpu_180
);

    ////////////////////////////////////////////////////////////
    // Fractional divider

    logic [9:0]  acc;
    logic [10:0] acc_next;
    logic [10:0] acc_wrap;

    assign acc_next = {1'b0, acc} + {1'b0, CEN_N};
    assign acc_wrap = acc_next - {1'b0, CEN_M};

    always_ff @(posedge clk) begin
        if (reset) begin
            acc    <= 10'd0;
            ce_12m <= 1'b0;
        end else begin
            ce_12m <= 1'b0;
            if (run) begin
                if (acc_next >= {1'b0, CEN_M}) begin
                    acc    <= acc_wrap[9:0];
                    ce_12m <= 1'b1;
                end else begin
                    acc    <= acc_next[9:0];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Paced CPU phases

    logic [9:0]  steady_count;
    logic [10:0] cpu_count; // Two phase steps per 12 MHz tick

    always_ff @(posedge clk) begin
        if (reset) begin
            steady_count <= 10'd0;
            cpu_count    <= 11'd0;
            ce_cpu       <= 1'b0;
            ce_cpu_180   <= 1'b0;
        end else begin
            ce_cpu     <= 1'b0;
            ce_cpu_180 <= 1'b0;

            if (ce_12m) steady_count <= steady_count + 10'd1;

            // Behind the steady count, so catch up one phase per clock
            if (rom_ready && run && cpu_count[10:1] != steady_count) begin
                ce_cpu     <= ~cpu_count[0];
                ce_cpu_180 <= cpu_count[0];
                cpu_count  <= cpu_count + 11'd1;
            end
        end
    end

endmodule

//--- hdl/addr_decode.sv
`timescale 1ns/1ns

module addr_decode import f2_glue_pkg::*; (
    cpu_bus_if.decode bus,
    output region_t   region
);

    logic [7:0] page; // Byte address bits 23..16

    assign page = bus.addr[22:15];

    function automatic logic in_range(
        input logic [7:0] value,
        input logic [7:0] first,
        input logic [7:0] last
    );
        in_range = (value >= first) && (value <= last);
    endfunction

    ////////////////////////////////////////////////////////////
    // Region select

    always_comb begin
        region = REG_NONE;

        // No device during idle or interrupt acknowledge
        if (!bus.as_n && bus.fc != FC_IACK) begin
            if (in_range(page, ROM_FIRST, ROM_LAST)) begin
                region = REG_ROM;
            end else if (page == WORK) begin
                region = REG_WORK;
            end else if (page == COLOR) begin
                region = REG_COLOR;
            end else if (page == IO) begin
                region = REG_IO;
            end else if (page == SOUND) begin
                region = REG_SOUND;
            end else if (in_range(page, SCREEN_FIRST, SCREEN_LAST)) begin
                region = REG_SCREEN;
            end else if (page == OBJECT) begin
                region = REG_OBJECT;
            end
        end
    end

endmodule

//--- hdl/read_mux.sv
`timescale 1ns/1ns

module read_mux import f2_glue_pkg::*; (
    cpu_bus_if.mux bus,
    input  region_t   region,

    input  word_t     rom_q,
    input  word_t     work_q,
    input  word_t     color_q,
    input  word_t     screen_q,
    input  word_t     object_q,
    input  logic [7:0] io_q,
    input  logic [3:0] sound_q,

    input  logic      rom_wait,
    input  logic      screen_wait,
    input  logic      color_wait,

    output word_t     cpu_din,
    output logic      cpu_dtack_n
);

    ////////////////////////////////////////////////////////////
    // Read data

    always_comb begin
        case (region)
            REG_ROM:    cpu_din = rom_q;
            REG_WORK:   cpu_din = work_q;
            REG_COLOR:  cpu_din = color_q;
            REG_SCREEN: cpu_din = screen_q;
            REG_OBJECT: cpu_din = object_q;
            REG_IO:     cpu_din = {8'h00, io_q};
            REG_SOUND:  cpu_din = {4'h0, sound_q, 8'h00}; // Sound comms on D11..8
            default:    cpu_din = 16'h0000;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // DTACK

    always_comb begin
        if (bus.as_n) begin
            cpu_dtack_n = 1'b1;
        end else begin
            case (region)
                REG_ROM:    cpu_dtack_n = rom_wait;
                REG_SCREEN: cpu_dtack_n = screen_wait;
                REG_COLOR:  cpu_dtack_n = color_wait;
                default:    cpu_dtack_n = 1'b0; // Unmapped ack too
            endcase
        end
    end

endmodule

//--- hdl/irq_ctrl.sv
`timescale 1ns/1ns

module irq_ctrl import f2_glue_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    cpu_bus_if.irq    bus,

    input  logic      vblank_n,
    input  logic      dma_n,

    output ipl_t      ipl_n
);

    logic vbl_prev;
    logic dma_prev;
    logic req_vbl;
    logic req_dma;

    ////////////////////////////////////////////////////////////
    // Acknowledge decode

    logic iack_cycle;
    logic clr_vbl;
    logic clr_dma;

    assign iack_cycle = ~bus.as_n & (bus.fc == FC_IACK) & ~bus.ds_n[0];
    assign clr_vbl    = iack_cycle & (bus.addr[2:0] == IRQ_VBL_LEVEL);
    assign clr_dma    = iack_cycle & (bus.addr[2:0] == IRQ_DMA_LEVEL);

    ////////////////////////////////////////////////////////////
    // Requests

    always_ff @(posedge clk) begin
        if (reset) begin
            vbl_prev <= 1'b1;
            dma_prev <= 1'b1;
            req_vbl  <= 1'b0;
            req_dma  <= 1'b0;
        end else begin
            vbl_prev <= vblank_n;
            dma_prev <= dma_n;

            if (vbl_prev && !vblank_n) req_vbl <= 1'b1; // Vblank start
            if (!dma_prev && dma_n)    req_dma <= 1'b1; // DMA finished

            // Clear beats set
            if (clr_vbl) req_vbl <= 1'b0;
            if (clr_dma) req_dma <= 1'b0;
        end
    end

    // Highest pending level wins
    assign ipl_n = req_dma ? ~IRQ_DMA_LEVEL :
                   req_vbl ? ~IRQ_VBL_LEVEL :
                   3'b111;

endmodule

//--- hdl/f2_cpu_glue.sv
`timescale 1ns/1ns

module f2_cpu_glue import f2_glue_pkg::*; #(
    parameter logic [9:0] CEN_N = 10'd172,
    parameter logic [9:0] CEN_M = 10'd765
) (
    input  logic       clk,
    input  logic       reset,

    // 68000 bus
    input  logic       cpu_as_n,
    input  logic [1:0] cpu_ds_n,
    input  logic       cpu_rw,
    input  fc_t        cpu_fc,
    input  cpu_addr_t  cpu_addr,
    input  word_t      cpu_dout,
    output word_t      cpu_din,
    output logic       cpu_dtack_n,
    output ipl_t       ipl_n,
    output region_t    region,

    input  logic       rom_ready,
    input  logic       run,
    input  logic       vblank_n,
    input  logic       dma_n,

    // Device read data and waits
    input  word_t      rom_q,
    input  word_t      work_q,
    input  word_t      color_q,
    input  word_t      screen_q,
    input  word_t      object_q,
    input  logic [7:0] io_q,
    input  logic [3:0] sound_q,
    input  logic       rom_wait,
    input  logic       screen_wait,
    input  logic       color_wait,

    output logic       ce_12m,
    output logic       ce_cpu,
    output logic       ce_cpu_180
);

    ////////////////////////////////////////////////////////////
    // Bus cycle

    cpu_bus_if bus ();

    assign bus.as_n = cpu_as_n;
    assign bus.ds_n = cpu_ds_n;
    assign bus.rw   = cpu_rw;
    assign bus.fc   = cpu_fc;
    assign bus.addr = cpu_addr;
    assign bus.dout = cpu_dout;

    ////////////////////////////////////////////////////////////
    // Blocks

    cpu_cen #(.CEN_N(CEN_N), .CEN_M(CEN_M)) i_cen (
        .clk, .reset,
        .rom_ready, .run,
        .ce_12m, .ce_cpu, .ce_cpu_180
    );

    addr_decode i_decode (.bus(bus.decode), .region);

    read_mux i_mux (
        .bus(bus.mux), .region,
        .rom_q, .work_q, .color_q, .screen_q, .object_q, .io_q, .sound_q,
        .rom_wait, .screen_wait, .color_wait,
        .cpu_din, .cpu_dtack_n
    );

    irq_ctrl i_irq (
        .clk, .reset,
        .bus(bus.irq),
        .vblank_n, .dma_n,
        .ipl_n
    );

endmodule

//--- sim/f2_cpu_glue_props.sv
`timescale 1ns/1ns

module f2_cpu_glue_props import f2_glue_pkg::*; (
    input logic clk,
    input logic reset,
    input logic cpu_as_n,
    input logic cpu_dtack_n,
    input ipl_t ipl_n,
    input logic ce_cpu,
    input logic ce_cpu_180
);

    // Two CPU phases never share a clock
    phase_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(ce_cpu && ce_cpu_180)
    ) else $error("ce_cpu and ce_cpu_180 pulsed together");

    ipl_idle_after_reset: assert property (
        @(posedge clk) reset |=> ipl_n == 3'b111
    ) else $error("ipl_n not idle after reset");

    dtack_idle: assert property (
        @(posedge clk) cpu_as_n |-> cpu_dtack_n // No ack outside a bus cycle
    ) else $error("DTACK low while address strobe is high");

endmodule

bind f2_cpu_glue f2_cpu_glue_props i_props (
    .clk(clk),
    .reset(reset),
    .cpu_as_n(cpu_as_n),
    .cpu_dtack_n(cpu_dtack_n),
    .ipl_n(ipl_n),
    .ce_cpu(ce_cpu),
    .ce_cpu_180(ce_cpu_180)
);

//--- sim/tb_f2_cpu_glue.sv
`timescale 1ns/1ns

module tb_f2_cpu_glue import f2_glue_pkg::*; ();

    localparam logic [9:0] CEN_N = 10'd172;
    localparam logic [9:0] CEN_M = 10'd765;
    localparam int PACE_CYCLES   = 2000;
    localparam string DATA_FILE  = "sim/f2_cpu_glue_testdata.txt";

    logic       clk, reset;
    logic       cpu_as_n, cpu_rw, cpu_dtack_n;
    logic [1:0] cpu_ds_n;
    fc_t        cpu_fc;
    cpu_addr_t  cpu_addr;
    word_t      cpu_dout, cpu_din;
    ipl_t       ipl_n;
    region_t    region;
    logic       rom_ready, run, vblank_n, dma_n;
    word_t      rom_q, work_q, color_q, screen_q, object_q;
    logic [7:0] io_q;
    logic [3:0] sound_q;
    logic       rom_wait, screen_wait, color_wait;
    logic       ce_12m, ce_cpu, ce_cpu_180;

    integer seed = 32'h834bc28b;
    int     n12_total;
    int     phase_total;
    logic   next_is_cpu;

    f2_cpu_glue #(.CEN_N(CEN_N), .CEN_M(CEN_M)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_region(input region_t got, input region_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s decoded %s, expected %s",
                $time, what, got.name(), exp.name()));
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s read %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_ipl(input ipl_t got, input ipl_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s ipl_n %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input int tol, input string what);
        if (got > exp + tol || got < exp - tol) begin
            abort_run($sformatf("Fail at %0t ns: %s counted %0d, expected %0d within %0d",
                $time, what, got, exp, tol));
        end
    endtask

    // Pulse totals since reset and a running phase order check
    always @(negedge clk) begin
        if (reset) begin
            n12_total   <= 0;
            phase_total <= 0;
            next_is_cpu <= 1'b1;
        end else begin
            if (ce_12m) n12_total <= n12_total + 1;
            if (ce_cpu || ce_cpu_180) begin
                check_bit(ce_cpu, next_is_cpu, "ce_cpu in phase order");
                next_is_cpu <= ~next_is_cpu;
                phase_total <= phase_total + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers

    task automatic drive_bus(input logic as_n, input fc_t fc, input logic [23:0] byte_addr);
        @(posedge clk);
        cpu_as_n <= as_n;
        cpu_ds_n <= as_n ? 2'b11 : 2'b00;
        cpu_fc   <= fc;
        cpu_addr <= byte_addr[23:1];
    endtask

    task automatic fill_random_data();
        logic [31:0] r;
        r = $random(seed);
        rom_q    <= r[15:0];
        work_q   <= r[31:16];
        r = $random(seed);
        color_q  <= r[15:0];
        screen_q <= r[31:16];
        r = $random(seed);
        object_q <= r[15:0];
        io_q     <= r[23:16];
        sound_q  <= r[27:24];
    endtask

    task automatic region_from_name(input string name, output region_t r);
        region_t probe;
        probe = probe.first();
        r = REG_NONE;
        repeat (probe.num()) begin
            if (probe.name() == name) begin
                r = probe;
                return;
            end
            probe = probe.next();
        end
        abort_run({"unknown region name in test data: ", name});
    endtask

    task automatic wait_ipl(input ipl_t want, input int limit, input string what);
        int   cycles;
        ipl_t start;
        cycles = 0;
        start  = ipl_n;
        @(negedge clk);
        while (ipl_n === start) begin
            if (cycles == limit) abort_run({"timed out waiting for interrupt level after ", what});
            cycles++;
            @(negedge clk);
        end
        check_ipl(ipl_n, want, what);
    endtask

    task automatic wait_caught_up(input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (phase_total < 2 * n12_total - 2) begin
            if (cycles == limit) abort_run("CPU enables did not catch up after the ROM stall");
            cycles++;
            @(negedge clk);
        end
        check_count(phase_total, 2 * n12_total, 2, "phase pulses after ROM stall");
    endtask

    ////////////////////////////////////////////////////////////
    // Vector file

    task automatic run_vector_file();
        int          fd;
        int          fields;
        int          count;
        string       line, kind, name;
        logic [2:0]  fc_bits;
        logic        as_bit, rw_v, sw_v, cw_v, want_bit;
        logic [23:0] byte_addr;
        word_t       rom_v, work_v, color_v, screen_v, object_v, want;
        logic [7:0]  io_v;
        logic [3:0]  sound_v;
        region_t     want_region;

        count = 0;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) abort_run({"could not open test data file ", DATA_FILE});
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") continue;
            count++;
            fields = $sscanf(line, "%s", kind);
            case (kind)
                "D": begin
                    fields = $sscanf(line, "%s %h %h %h %s", kind, fc_bits, as_bit,
                        byte_addr, name);
                    if (fields != 5) abort_run({"malformed decode vector: ", line});
                    region_from_name(name, want_region);
                    drive_bus(as_bit, fc_t'(fc_bits), byte_addr);
                    fill_random_data();
                    @(negedge clk);
                    check_region(region, want_region, $sformatf("vector %0d", count));
                end
                "R": begin
                    fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", kind, byte_addr,
                        rom_v, work_v, color_v, screen_v, object_v, io_v, sound_v, want);
                    if (fields != 10) abort_run({"malformed read vector: ", line});
                    drive_bus(1'b0, FC_SUPER_DATA, byte_addr);
                    rom_q    <= rom_v;
                    work_q   <= work_v;
                    color_q  <= color_v;
                    screen_q <= screen_v;
                    object_q <= object_v;
                    io_q     <= io_v;
                    sound_q  <= sound_v;
                    @(negedge clk);
                    check_word(cpu_din, want, $sformatf("vector %0d", count));
                end
                "W": begin
                    fields = $sscanf(line, "%s %h %h %h %h %h %h", kind, as_bit, byte_addr,
                        rw_v, sw_v, cw_v, want_bit);
                    if (fields != 7) abort_run({"malformed DTACK vector: ", line});
                    drive_bus(as_bit, FC_USER_PROG, byte_addr);
                    fill_random_data();
                    rom_wait    <= rw_v;
                    screen_wait <= sw_v;
                    color_wait  <= cw_v;
                    @(negedge clk);
                    check_bit(cpu_dtack_n, want_bit, $sformatf("DTACK of vector %0d", count));
                end
                default: abort_run({"unknown vector kind in test data: ", line});
            endcase
        end
        $fclose(fd);
        if (count == 0) abort_run("test data file holds no vectors");
        drive_bus(1'b1, FC_SUPER_DATA, 24'h000000);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        int phase_mark;

        reset       = 1'b1;
        cpu_as_n    = 1'b1;
        cpu_ds_n    = 2'b11;
        cpu_rw      = 1'b1;
        cpu_fc      = FC_SUPER_DATA;
        cpu_addr    = '0;
        cpu_dout    = '0;
        rom_ready   = 1'b1;
        run         = 1'b1;
        vblank_n    = 1'b1;
        dma_n       = 1'b1;
        rom_q       = '0;
        work_q      = '0;
        color_q     = '0;
        screen_q    = '0;
        object_q    = '0;
        io_q        = '0;
        sound_q     = '0;
        rom_wait    = 1'b0;
        screen_wait = 1'b0;
        color_wait  = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Free running enables from reset
        repeat (PACE_CYCLES) @(negedge clk);
        check_count(n12_total, PACE_CYCLES * int'(CEN_N) / int'(CEN_M), 1, "ce_12m pulses");
        check_count(phase_total, 2 * n12_total, 2, "CPU phase pulses");

        @(posedge clk);
        rom_ready <= 1'b0;
        repeat (2) @(negedge clk); // Last pulse decided before the stall
        phase_mark = phase_total;
        repeat (200) @(negedge clk);
        check_count(phase_total, phase_mark, 0, "phase pulses during ROM stall");
        @(posedge clk);
        rom_ready <= 1'b1;
        wait_caught_up(500);

        run_vector_file();

        ////////////////////////////////////////////////////////////
        // Interrupts

        @(negedge clk);
        check_ipl(ipl_n, 3'b111, "idle before interrupts");
        @(posedge clk);
        vblank_n <= 1'b0;
        wait_ipl(3'b010, 10, "vblank start");
        @(posedge clk);
        vblank_n <= 1'b1;
        dma_n    <= 1'b0;
        @(posedge clk);
        dma_n <= 1'b1;
        wait_ipl(3'b001, 10, "DMA end");

        drive_bus(1'b0, FC_IACK, {20'hFFFFF, 3'd6, 1'b0});
        wait_ipl(3'b010, 10, "acknowledge at level 6");
        drive_bus(1'b1, FC_SUPER_DATA, 24'h000000);
        drive_bus(1'b0, FC_IACK, {20'hFFFFF, 3'd5, 1'b0});
        wait_ipl(3'b111, 10, "acknowledge at level 5");
        drive_bus(1'b1, FC_SUPER_DATA, 24'h000000);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- f2_cpu_glue.f
hdl/f2_glue_pkg.sv
hdl/cpu_bus_if.sv
hdl/cpu_cen.sv
hdl/addr_decode.sv
hdl/read_mux.sv
hdl/irq_ctrl.sv
hdl/f2_cpu_glue.sv
sim/f2_cpu_glue_props.sv
sim/tb_f2_cpu_glue.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --top-module tb_f2_cpu_glue -f f2_cpu_glue.f -o tb_f2_cpu_glue

status=0
./obj_dir/tb_f2_cpu_glue > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -q "^ALL CHECKS PASSED$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1

//--- sim/f2_cpu_glue_testdata.txt
# One vector per line, kind letter first, all values in hex, byte addresses 24 bits
# D fc as_n byte_addr expected_region
D 5 0 000000 REG_ROM
D 6 0 0FFFFE REG_ROM
D 1 0 100000 REG_WORK
D 1 0 10FFFE REG_WORK
D 5 0 110000 REG_NONE
D 5 0 200000 REG_COLOR
D 5 0 20FFFE REG_COLOR
D 5 0 210000 REG_NONE
D 1 0 300000 REG_IO
D 1 0 310000 REG_NONE
D 5 0 320000 REG_SOUND
D 5 0 330000 REG_NONE
D 5 0 800000 REG_SCREEN
D 2 0 81FFFE REG_SCREEN
D 5 0 820000 REG_NONE
D 5 0 900000 REG_OBJECT
D 5 0 910000 REG_NONE
D 5 0 FF0000 REG_NONE
D 7 0 000000 REG_NONE
D 7 0 100000 REG_NONE
D 5 1 000000 REG_NONE
D 5 1 900000 REG_NONE
# R byte_addr rom work color screen object io sound expected_din
R 012340 1111 2222 3333 4444 5555 66 7 1111
R 100010 A001 B002 C003 D004 E005 F6 9 B002
R 200000 0F0F 1E1E 2D2D 3C3C 4B4B 5A 1 2D2D
R 808000 8000 4001 2002 1003 0804 01 2 1003
R 900100 FFFF 0000 AAAA 5555 1234 C3 F 1234
R 300000 DEAD BEEF CAFE F00D 7777 A5 3 00A5
R 320002 DEAD BEEF CAFE F00D 7777 A5 C 0C00
R 500000 DEAD BEEF CAFE F00D 7777 A5 C 0000
# W as_n byte_addr rom_wait screen_wait color_wait expected_dtack_n
W 0 000000 1 0 0 1
W 0 000000 0 1 1 0
W 0 800000 0 1 0 1
W 0 81FFFE 1 0 1 0
W 0 200000 0 0 1 1
W 0 200000 1 1 0 0
W 0 100000 1 1 1 0
W 0 500000 1 1 1 0
W 1 000000 0 0 0 1
